// File: decodeStage.f
+incdir+hdl
hdl/rvDecodePkg.sv
hdl/controlDecoder.sv
hdl/immediateGen.sv
hdl/decodeExecReg.sv
hdl/decodeStage.sv
bench/decodeStageTb.sv

// File: Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= decodeStageTb
FILELIST  ?= decodeStage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= TESTBENCH PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run fails unless the pass line shows up in the output
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/decodeStageTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvDecode_macros.svh"

module decodeStageTb
    import rvDecodePkg::*;
();

    localparam int ClkPeriod   = 10;
    localparam int NumDirected = 16;
    localparam int NumFlush    = 3;
    localparam int NumRandom   = 300;
    localparam int NumTests    = NumDirected + NumFlush + NumRandom;

    // what execute should see for one accepted instruction
    typedef struct packed {
        logic [`RV_INSTR_W-1:0]    word;
        logic                      regWrite;
        resultSrc_t                resultSrc;
        logic                      memWrite;
        logic                      aluSrcA;
        logic                      aluSrcB;
        aluOp_t                    aluControl;
        logic                      jump;
        logic                      branch;
        logic                      illegal;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [`RV_XLEN-1:0]       imm;
    } expected_t;

    logic                      clk = 1'b0;
    logic                      rstN;
    logic                      instrValid;
    instrWord_t                instr;
    logic                      flush;
    logic                      ctrlValid;
    logic                      regWriteE;
    resultSrc_t                resultSrcE;
    logic                      memWriteE;
    logic                      aluSrcAE;
    logic                      aluSrcBE;
    aluOp_t                    aluControlE;
    logic                      jumpE;
    logic                      branchE;
    logic [2:0]                funct3E;
    logic [`RV_REG_ADDR_W-1:0] rs1E;
    logic [`RV_REG_ADDR_W-1:0] rs2E;
    logic [`RV_REG_ADDR_W-1:0] rdE;
    logic [`RV_XLEN-1:0]       immExtE;
    logic                      illegalE;

    expected_t   expectQ[$];
    opcode_t     legalOps[$] = '{OpLui, OpAuipc, OpJal, OpJalr, OpBranch,
                                 OpLoad, OpStore, OpImm, OpReg};
    logic [31:0] seed = 32'd93090;
    // set when the inputs of this cycle should come out next cycle
    logic        dueNext = 1'b0;

    decodeStage dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .flush      (flush),
        .ctrlValid  (ctrlValid),
        .regWriteE  (regWriteE),
        .resultSrcE (resultSrcE),
        .memWriteE  (memWriteE),
        .aluSrcAE   (aluSrcAE),
        .aluSrcBE   (aluSrcBE),
        .aluControlE(aluControlE),
        .jumpE      (jumpE),
        .branchE    (branchE),
        .funct3E    (funct3E),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .immExtE    (immExtE),
        .illegalE   (illegalE)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    // two LCG steps, upper halves only since the low bits cycle quickly
    function automatic logic [31:0] nextRand();
        logic [31:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi   = seed;
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {hi[31:16], seed[31:16]};
    endfunction

    function automatic logic [31:0] packFields(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd, input logic [6:0] op);
        return {f7, rs2, rs1, f3, rd, op};
    endfunction

    function automatic aluOp_t aluForFunct3(input logic [2:0] f3);
        case (f3)
            3'd0:    return AluAdd;
            3'd1:    return AluSll;
            3'd2:    return AluSlt;
            3'd3:    return AluSltu;
            3'd4:    return AluXor;
            3'd5:    return AluSrl;
            3'd6:    return AluOr;
            default: return AluAnd;
        endcase
    endfunction

    // RV32I decode straight from the ISA bit positions
    function automatic expected_t decodeRef(input logic [31:0] w);
        expected_t           e;
        logic [`RV_XLEN-1:0] immI;
        logic [`RV_XLEN-1:0] immS;
        logic [`RV_XLEN-1:0] immB;
        logic [`RV_XLEN-1:0] immU;
        logic [`RV_XLEN-1:0] immJ;
        immI = {{20{w[31]}}, w[31:20]};
        immS = {{20{w[31]}}, w[31:25], w[11:7]};
        immB = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        immU = {w[31:12], 12'h000};
        immJ = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        e        = '0;
        e.word   = w;
        e.funct3 = w[14:12];
        e.rs1    = w[19:15];
        e.rs2    = w[24:20];
        e.rd     = w[11:7];
        case (w[6:0])
            OpLui: begin
                e.regWrite   = 1'b1;
                e.aluSrcB    = 1'b1;
                e.aluControl = AluPassB;
                e.imm        = immU;
            end
            OpAuipc: begin
                e.regWrite = 1'b1;
                e.aluSrcA  = 1'b1;
                e.aluSrcB  = 1'b1;
                e.imm      = immU;
            end
            OpJal: begin
                e.regWrite  = 1'b1;
                e.resultSrc = ResPcPlus4;
                e.aluSrcA   = 1'b1;
                e.aluSrcB   = 1'b1;
                e.jump      = 1'b1;
                e.imm       = immJ;
            end
            OpJalr: begin
                e.regWrite  = 1'b1;
                e.resultSrc = ResPcPlus4;
                e.aluSrcB   = 1'b1;
                e.jump      = 1'b1;
                e.imm       = immI;
            end
            OpBranch: begin
                e.aluControl = AluSub;
                e.branch     = 1'b1;
                e.imm        = immB;
            end
            OpLoad: begin
                e.regWrite  = 1'b1;
                e.resultSrc = ResMem;
                e.aluSrcB   = 1'b1;
                e.imm       = immI;
            end
            OpStore: begin
                e.memWrite = 1'b1;
                e.aluSrcB  = 1'b1;
                e.imm      = immS;
            end
            OpImm: begin
                e.regWrite   = 1'b1;
                e.aluSrcB    = 1'b1;
                e.aluControl = aluForFunct3(w[14:12]);
                e.imm        = immI;
            end
            OpReg: begin
                e.regWrite   = 1'b1;
                e.aluControl = (w[14:12] == 3'b000 && w[30]) ? AluSub : aluForFunct3(w[14:12]);
            end
            default: begin
                e.illegal = 1'b1;
            end
        endcase
        return e;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    task automatic checkWord(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED at %0t: %s is 0x%08h, expected 0x%08h",
                               $time, what, got, exp));
        end
    endtask

    task automatic checkAluOp(input string what, input aluOp_t got, input aluOp_t exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED at %0t: %s is %s, expected %s",
                               $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic checkResultSrc(input string what, input resultSrc_t got,
                                  input resultSrc_t exp);
        if (got !== exp) begin
            abortRun($sformatf("FAILED at %0t: %s is %s, expected %s",
                               $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic compareOutputs(input expected_t e);
        string tag;
        tag = $sformatf(" of 0x%08h", e.word);
        checkBit({"illegalE", tag}, illegalE, e.illegal);
        checkBit({"regWriteE", tag}, regWriteE, e.regWrite);
        checkBit({"memWriteE", tag}, memWriteE, e.memWrite);
        checkBit({"jumpE", tag}, jumpE, e.jump);
        checkBit({"branchE", tag}, branchE, e.branch);
        checkWord({"funct3E", tag}, 32'(funct3E), 32'(e.funct3));
        checkWord({"rs1E", tag}, 32'(rs1E), 32'(e.rs1));
        checkWord({"rs2E", tag}, 32'(rs2E), 32'(e.rs2));
        checkWord({"rdE", tag}, 32'(rdE), 32'(e.rd));
        // the remaining fields mean nothing for an illegal word
        if (!e.illegal) begin
            checkResultSrc({"resultSrcE", tag}, resultSrcE, e.resultSrc);
            checkAluOp({"aluControlE", tag}, aluControlE, e.aluControl);
            checkBit({"aluSrcAE", tag}, aluSrcAE, e.aluSrcA);
            checkBit({"aluSrcBE", tag}, aluSrcBE, e.aluSrcB);
            // register arithmetic carries no immediate
            if (e.word[6:0] != OpReg) begin
                checkWord({"immExtE", tag}, immExtE, e.imm);
            end
        end
    endtask

    task automatic issue(input logic [31:0] word, input logic flushIn);
        instrValid = 1'b1;
        instr      = word;
        flush      = flushIn;
        if (!flushIn) begin
            expectQ.push_back(decodeRef(word));
        end
        @(posedge clk);
        #1;
    endtask

    task automatic idleCycle(input logic [31:0] word, input logic flushIn);
        instrValid = 1'b0;
        instr      = word;
        flush      = flushIn;
        @(posedge clk);
        #1;
    endtask

    // outputs settle at the rising edge, so look at the falling one
    always @(negedge clk) begin
        if (rstN) begin
            if (ctrlValid) begin
                if (expectQ.size() == 0 || !dueNext) begin
                    abortRun("ctrlValid went high with no accepted strobe in the cycle before");
                end else begin
                    compareOutputs(expectQ.pop_front());
                end
            end else begin
                if (dueNext) begin
                    abortRun("ctrlValid missing in the cycle after an accepted strobe");
                end else begin
                    checkBit("regWriteE while idle", regWriteE, 1'b0);
                    checkBit("memWriteE while idle", memWriteE, 1'b0);
                    checkBit("jumpE while idle", jumpE, 1'b0);
                    checkBit("branchE while idle", branchE, 1'b0);
                end
            end
            dueNext = instrValid && !flush;
        end
    end

    initial begin
        #((NumTests + 50) * ClkPeriod);
        abortRun("watchdog expired before the test sequence finished");
    end

    initial begin
        logic [31:0] word;
        logic [31:0] pick;
        int          idx;
        rstN       = 1'b0;
        instrValid = 1'b0;
        instr      = '0;
        flush      = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rstN = 1'b1;
        repeat (5) idleCycle(32'h0, 1'b0);

        // one of each class, back to back
        issue(packFields(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, OpReg), 1'b0);
        issue(packFields(7'h20, 5'd5, 5'd4, 3'd0, 5'd6, OpReg), 1'b0);
        issue(packFields(7'h00, 5'd8, 5'd7, 3'd3, 5'd9, OpReg), 1'b0);
        issue(packFields(7'h00, 5'd11, 5'd10, 3'd4, 5'd12, OpReg), 1'b0);
        issue(packFields(7'h7f, 5'h1f, 5'd2, 3'd0, 5'd13, OpImm), 1'b0);
        issue(packFields(7'h20, 5'd3, 5'd14, 3'd5, 5'd15, OpImm), 1'b0);
        issue(packFields(7'h40, 5'h10, 5'd16, 3'd2, 5'd17, OpLoad), 1'b0);
        issue(packFields(7'h7f, 5'd18, 5'd19, 3'd2, 5'h1c, OpStore), 1'b0);
        issue(packFields(7'h7e, 5'd20, 5'd21, 3'd0, 5'h1f, OpBranch), 1'b0);
        issue(packFields(7'h01, 5'd22, 5'd23, 3'd1, 5'h0e, OpBranch), 1'b0);
        issue(packFields(7'h5a, 5'h0c, 5'h1b, 3'd3, 5'd24, OpLui), 1'b0);
        issue(packFields(7'h12, 5'h05, 5'h09, 3'd6, 5'd25, OpAuipc), 1'b0);
        issue(packFields(7'h7f, 5'h1e, 5'h11, 3'd7, 5'd1, OpJal), 1'b0);
        issue(packFields(7'h00, 5'h08, 5'd26, 3'd0, 5'd1, OpJalr), 1'b0);
        // system and fence fall outside the decoded set
        issue(packFields(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'b1110011), 1'b0);
        issue(packFields(7'h00, 5'd0, 5'd0, 3'd0, 5'd0, 7'b0001111), 1'b0);

        issue(packFields(7'h7f, 5'd3, 5'd4, 3'd2, 5'h1f, OpStore), 1'b1);
        issue(packFields(7'h40, 5'h00, 5'd6, 3'd0, 5'd7, OpImm), 1'b0);
        issue(packFields(7'h3c, 5'h0a, 5'd9, 3'd1, 5'd2, OpJal), 1'b1);

        for (int i = 0; i < NumRandom; i++) begin
            word = nextRand();
            pick = nextRand();
            idx  = int'(pick[7:4]) % legalOps.size();
            // most words get a legal opcode, the rest stay raw
            if (pick[1:0] != 2'b00) begin
                word[6:0] = legalOps[idx];
            end
            if (pick[10:8] == 3'b000) begin
                idleCycle(word, pick[11]);
            end else begin
                issue(word, pick[14:12] == 3'b000);
            end
        end

        instrValid = 1'b0;
        flush      = 1'b0;
        repeat (3) @(posedge clk);
        if (expectQ.size() != 0) begin
            abortRun("accepted instructions never came out of the DUT");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: hdl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvDecode_macros.svh"

module decodeStage
    import rvDecodePkg::*;
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      instrValid,
    input  instrWord_t                instr,
    input  logic                      flush,
    output logic                      ctrlValid,
    output logic                      regWriteE,
    output resultSrc_t                resultSrcE,
    output logic                      memWriteE,
    output logic                      aluSrcAE,
    output logic                      aluSrcBE,
    output aluOp_t                    aluControlE,
    output logic                      jumpE,
    output logic                      branchE,
    output logic [2:0]                funct3E,
    output logic [`RV_REG_ADDR_W-1:0] rs1E,
    output logic [`RV_REG_ADDR_W-1:0] rs2E,
    output logic [`RV_REG_ADDR_W-1:0] rdE,
    output logic [`RV_XLEN-1:0]       immExtE,
    output logic                      illegalE
);

    // decode-side controls
    immFmt_t    immFmtD;
    logic       regWriteD;
    resultSrc_t resultSrcD;
    logic       memWriteD;
    logic       aluSrcAD;
    logic       aluSrcBD;
    aluOp_t     aluControlD;
    logic       jumpD;
    logic       branchD;
    logic       illegalD;

    logic [`RV_XLEN-1:0] immI;
    logic [`RV_XLEN-1:0] immS;
    logic [`RV_XLEN-1:0] immB;
    logic [`RV_XLEN-1:0] immU;
    logic [`RV_XLEN-1:0] immJ;

    controlDecoder controlDecoder (
        .instr     (instr),
        .immFmt    (immFmtD),
        .regWrite  (regWriteD),
        .resultSrc (resultSrcD),
        .memWrite  (memWriteD),
        .aluSrcA   (aluSrcAD),
        .aluSrcB   (aluSrcBD),
        .aluControl(aluControlD),
        .jump      (jumpD),
        .branch    (branchD),
        .illegal   (illegalD)
    );

    // every format built in parallel, picked in the register stage
    immediateGen immediateGen (
        .instr(instr),
        .immI (immI),
        .immS (immS),
        .immB (immB),
        .immU (immU),
        .immJ (immJ)
    );

    decodeExecReg decodeExecReg (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .flush      (flush),
        .instr      (instr),
        .immFmt     (immFmtD),
        .regWrite   (regWriteD),
        .resultSrc  (resultSrcD),
        .memWrite   (memWriteD),
        .aluSrcA    (aluSrcAD),
        .aluSrcB    (aluSrcBD),
        .aluControl (aluControlD),
        .jump       (jumpD),
        .branch     (branchD),
        .illegal    (illegalD),
        .immI       (immI),
        .immS       (immS),
        .immB       (immB),
        .immU       (immU),
        .immJ       (immJ),
        .ctrlValid  (ctrlValid),
        .regWriteE  (regWriteE),
        .resultSrcE (resultSrcE),
        .memWriteE  (memWriteE),
        .aluSrcAE   (aluSrcAE),
        .aluSrcBE   (aluSrcBE),
        .aluControlE(aluControlE),
        .jumpE      (jumpE),
        .branchE    (branchE),
        .funct3E    (funct3E),
        .rs1E       (rs1E),
        .rs2E       (rs2E),
        .rdE        (rdE),
        .immExtE    (immExtE),
        .illegalE   (illegalE)
    );

endmodule

`default_nettype wire

// File: hdl/decodeExecReg.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvDecode_macros.svh"

module decodeExecReg
    import rvDecodePkg::*;
(
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      instrValid,
    input  logic                      flush,
    input  instrWord_t                instr,
    input  immFmt_t                   immFmt,
    input  logic                      regWrite,
    input  resultSrc_t                resultSrc,
    input  logic                      memWrite,
    input  logic                      aluSrcA,
    input  logic                      aluSrcB,
    input  aluOp_t                    aluControl,
    input  logic                      jump,
    input  logic                      branch,
    input  logic                      illegal,
    input  logic [`RV_XLEN-1:0]       immI,
    input  logic [`RV_XLEN-1:0]       immS,
    input  logic [`RV_XLEN-1:0]       immB,
    input  logic [`RV_XLEN-1:0]       immU,
    input  logic [`RV_XLEN-1:0]       immJ,
    output logic                      ctrlValid,
    output logic                      regWriteE,
    output resultSrc_t                resultSrcE,
    output logic                      memWriteE,
    output logic                      aluSrcAE,
    output logic                      aluSrcBE,
    output aluOp_t                    aluControlE,
    output logic                      jumpE,
    output logic                      branchE,
    output logic [2:0]                funct3E,
    output logic [`RV_REG_ADDR_W-1:0] rs1E,
    output logic [`RV_REG_ADDR_W-1:0] rs2E,
    output logic [`RV_REG_ADDR_W-1:0] rdE,
    output logic [`RV_XLEN-1:0]       immExtE,
    output logic                      illegalE
);

    logic               accept;
    logic [`RV_XLEN-1:0] immExt;

    // a flushed strobe never reaches execute
    assign accept = instrValid & ~flush;

    always_comb begin
        case (immFmt)
            ImmS:    immExt = immS;
            ImmB:    immExt = immB;
            ImmU:    immExt = immU;
            ImmJ:    immExt = immJ;
            default: immExt = immI;
        endcase
    end

    // valid and side-effecting controls
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ctrlValid <= 1'b0;
            regWriteE <= 1'b0;
            memWriteE <= 1'b0;
            jumpE     <= 1'b0;
            branchE   <= 1'b0;
        end else begin
            ctrlValid <= accept;
            regWriteE <= accept & regWrite;
            memWriteE <= accept & memWrite;
            jumpE     <= accept & jump;
            branchE   <= accept & branch;
        end
    end

    // payload, held while idle
    always_ff @(posedge clk) begin
        if (accept) begin
            resultSrcE  <= resultSrc;
            aluSrcAE    <= aluSrcA;
            aluSrcBE    <= aluSrcB;
            aluControlE <= aluControl;
            funct3E     <= instr.regs.funct3;
            rs1E        <= instr.regs.rs1;
            rs2E        <= instr.regs.rs2;
            rdE         <= instr.regs.rd;
            immExtE     <= immExt;
            illegalE    <= illegal;
        end
    end

    // decoder must never pair illegal with a write
    illegalNoWrite: assert property (@(posedge clk) disable iff (!rstN)
        (ctrlValid && illegalE) |-> (!regWriteE && !memWriteE))
        else $error("illegal instruction reached execute with a write enable");

    // only defined formats may reach the immediate mux
    fmtKnown: assert property (@(posedge clk) disable iff (!rstN)
        accept |-> (immFmt inside {ImmI, ImmS, ImmB, ImmU, ImmJ}))
        else $error("undefined immediate format on an accepted instruction");

    storeNoRegWrite: assert property (@(posedge clk) disable iff (!rstN)
        (accept && memWrite) |-> !regWrite)
        else $error("store decoded with a register write");

endmodule

`default_nettype wire

// File: hdl/immediateGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "rvDecode_macros.svh"

module immediateGen
    import rvDecodePkg::*;
(
    input  instrWord_t           instr,
    output logic [`RV_XLEN-1:0] immI,
    output logic [`RV_XLEN-1:0] immS,
    output logic [`RV_XLEN-1:0] immB,
    output logic [`RV_XLEN-1:0] immU,
    output logic [`RV_XLEN-1:0] immJ
);

    // instr[31:7], so instr bit k sits at raw[k-7]
    logic [`RV_INSTR_W-8:0] raw;
    logic                   signBit;

    assign raw     = instr.imm.upper;
    assign signBit = raw[24];

    // imm[11:0] = instr[31:20]
    assign immI = {{(`RV_XLEN-12){signBit}}, raw[24:13]};

    // imm[11:5] = instr[31:25], imm[4:0] = instr[11:7]
    assign immS = {{(`RV_XLEN-12){signBit}}, raw[24:18], raw[4:0]};

    // imm[12|10:5|4:1|11], lsb always zero
    assign immB = {{(`RV_XLEN-12){signBit}}, raw[0], raw[23:18], raw[4:1], 1'b0};

    // upper 20 bits, low 12 cleared
    assign immU = {raw[24:5], 12'b0};

    // imm[20|10:1|11|19:12], lsb always zero
    assign immJ = {{(`RV_XLEN-20){signBit}}, raw[12:5], raw[13], raw[23:14], 1'b0};

endmodule

`default_nettype wire

// File: hdl/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

module controlDecoder
    import rvDecodePkg::*;
(
    input  instrWord_t instr,
    output immFmt_t    immFmt,
    output logic       regWrite,
    output resultSrc_t resultSrc,
    output logic       memWrite,
    output logic       aluSrcA,
    output logic       aluSrcB,
    output aluOp_t     aluControl,
    output logic       jump,
    output logic       branch,
    output logic       illegal
);

    opcode_t opcode;
    aluOp_t  functOp;

    assign opcode = opcode_t'(instr.regs.opcode);

    // funct3 to ALU operation, shared by OP and OP-IMM
    always_comb begin
        case (instr.regs.funct3)
            3'b000:  functOp = AluAdd;
            3'b001:  functOp = AluSll;
            3'b010:  functOp = AluSlt;
            3'b011:  functOp = AluSltu;
            3'b100:  functOp = AluXor;
            3'b101:  functOp = AluSrl;
            3'b110:  functOp = AluOr;
            default: functOp = AluAnd;
        endcase
    end

    always_comb begin
        immFmt     = ImmI;
        regWrite   = 1'b0;
        resultSrc  = ResAlu;
        memWrite   = 1'b0;
        aluSrcA    = 1'b0;
        aluSrcB    = 1'b0;
        aluControl = AluAdd;
        jump       = 1'b0;
        branch     = 1'b0;
        illegal    = 1'b0;

        case (opcode)
            OpLui: begin
                immFmt     = ImmU;
                regWrite   = 1'b1;
                aluSrcB    = 1'b1;
                aluControl = AluPassB;
            end
            OpAuipc: begin
                immFmt   = ImmU;
                regWrite = 1'b1;
                aluSrcA  = 1'b1;
                aluSrcB  = 1'b1;
            end
            OpJal: begin
                // ALU forms the target, rd gets pc+4
                immFmt    = ImmJ;
                regWrite  = 1'b1;
                resultSrc = ResPcPlus4;
                aluSrcA   = 1'b1;
                aluSrcB   = 1'b1;
                jump      = 1'b1;
            end
            OpJalr: begin
                regWrite  = 1'b1;
                resultSrc = ResPcPlus4;
                aluSrcB   = 1'b1;
                jump      = 1'b1;
            end
            OpBranch: begin
                // compare rs1 against rs2
                immFmt     = ImmB;
                aluControl = AluSub;
                branch     = 1'b1;
            end
            OpLoad: begin
                regWrite  = 1'b1;
                resultSrc = ResMem;
                aluSrcB   = 1'b1;
            end
            OpStore: begin
                immFmt   = ImmS;
                memWrite = 1'b1;
                aluSrcB  = 1'b1;
            end
            OpImm: begin
                regWrite   = 1'b1;
                aluSrcB    = 1'b1;
                aluControl = functOp;
            end
            OpReg: begin
                regWrite = 1'b1;
                // bit 30 picks SUB over ADD
                if (instr.regs.funct3 == 3'b000 && instr.regs.funct7[5]) begin
                    aluControl = AluSub;
                end else begin
                    aluControl = functOp;
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/rvDecodePkg.sv
`default_nettype none

`include "rvDecode_macros.svh"

package rvDecodePkg;

    // base opcodes of the supported RV32I classes
    typedef enum logic [6:0] {
        OpLui    = 7'b0110111,
        OpAuipc  = 7'b0010111,
        OpJal    = 7'b1101111,
        OpJalr   = 7'b1100111,
        OpBranch = 7'b1100011,
        OpLoad   = 7'b0000011,
        OpStore  = 7'b0100011,
        OpImm    = 7'b0010011,
        OpReg    = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        AluAdd   = 4'd0,
        AluSub   = 4'd1,
        AluAnd   = 4'd2,
        AluOr    = 4'd3,
        AluXor   = 4'd4,
        AluSlt   = 4'd5,
        AluSltu  = 4'd6,
        AluSll   = 4'd7,
        AluSrl   = 4'd8,
        AluPassB = 4'd9
    } aluOp_t;

    typedef enum logic [2:0] {ImmI, ImmS, ImmB, ImmU, ImmJ} immFmt_t;

    typedef enum logic [1:0] {ResAlu, ResMem, ResPcPlus4} resultSrc_t;

    // register fields, R-type layout
    typedef struct packed {
        logic [6:0]                funct7;
        logic [`RV_REG_ADDR_W-1:0] rs2;
        logic [`RV_REG_ADDR_W-1:0] rs1;
        logic [2:0]                funct3;
        logic [`RV_REG_ADDR_W-1:0] rd;
        logic [6:0]                opcode;
    } regView_t;

    // everything above the opcode carries immediate bits in some format
    typedef struct packed {
        logic [`RV_INSTR_W-8:0] upper;
        logic [6:0]             opcode;
    } immView_t;

    typedef union packed {
        regView_t regs;
        immView_t imm;
    } instrWord_t;

endpackage

`default_nettype wire

// File: hdl/rvDecode_macros.svh
`ifndef RV_DECODE_MACROS_SVH
`define RV_DECODE_MACROS_SVH

// widths fixed by the RV32I base ISA
`define RV_XLEN        32
`define RV_REG_ADDR_W  5
`define RV_INSTR_W     32

`endif
